/* source/zmem_pkg.sv */
`default_nettype none

package zmem_pkg;

	// z80 address bus width
	localparam int ZA_W = 16;

	// one 16k page number per window
	localparam int PAGE_W = 8;

	// dram halfword address, page plus za[13:1]
	localparam int DA_W = 21;

	// cpu clock select
	// codes 2'b10 and 2'b11 both run at 14 MHz
	typedef enum logic [1:0] {
		T35 = 2'b00,
		T7  = 2'b01,
		T14 = 2'b10
	} turbo_e;

	// dram sequencer phase, c0..c3
	typedef logic [1:0] phase_t;

	localparam phase_t PH_C2 = 2'd2;
	localparam phase_t PH_C3 = 2'd3;

endpackage

`default_nettype wire

/* source/zmem_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// mapped access, window mapper to request stage
interface zacc_if import zmem_pkg::*; ();
	logic            ramrd;
	logic            ramwr;
	logic            opfetch;
	logic            dram_beg;
	logic [DA_W-1:0] daddr;
	logic            bsel;
	logic [7:0]      wdata;
	logic            romsel;
	logic            iocyc;

	modport mapper (output ramrd, ramwr, opfetch, dram_beg, daddr, bsel, wdata, romsel, iocyc);
	modport ctl    (input  ramrd, ramwr, opfetch, dram_beg, daddr, bsel, wdata, romsel, iocyc);
endinterface

// cpu port of the dram slot controller
interface dram_cpu_if import zmem_pkg::*; ();
	logic            cpu_req;
	logic            cpu_rnw;
	logic [DA_W-1:0] cpu_addr;
	logic [7:0]      cpu_wrdata;
	logic            cpu_wrbsel;
	logic            cpu_next;
	logic            cpu_strobe;
	logic [15:0]     cpu_rddata;

	modport cpu  (output cpu_req, cpu_rnw, cpu_addr, cpu_wrdata, cpu_wrbsel,
	              input  cpu_next, cpu_strobe, cpu_rddata);
	modport slot (input  cpu_req, cpu_rnw, cpu_addr, cpu_wrdata, cpu_wrbsel,
	              output cpu_next, cpu_strobe, cpu_rddata);
endinterface

`default_nettype wire

/* source/zclk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module zclk_gen import zmem_pkg::*; (
	input  logic   fclk,
	input  logic   rst_n,
	input  turbo_e turbo,
	input  logic   stall,
	output logic   zpos,
	output logic   zneg,
	output phase_t phase
);

	logic [2:0] div;
	logic       run;
	logic       pos_pt;
	logic       neg_pt;

	// edge points inside the divider period
	always_comb
	begin
		case (turbo)
			T35:
			begin
				// period 8, edges 4 apart
				pos_pt = (div == 3'd3);
				neg_pt = (div == 3'd7);
			end
			T7:
			begin
				pos_pt = (div[1:0] == 2'd1);
				neg_pt = (div[1:0] == 2'd3);
			end
			default:
			begin
				// 14 MHz, an edge every fclk
				pos_pt = ~div[0];
				neg_pt = div[0];
			end
		endcase
	end

	// stalled cpu clock shows no edges
	assign zpos = run & ~stall & pos_pt;
	assign zneg = run & ~stall & neg_pt;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div   <= '0;
			run   <= 1'b0;
			phase <= '0;
		end
		else
		begin
			run   <= 1'b1;
			// dram phase never stops
			phase <= phase + 1'b1;
			if (!stall)
				div <= div + 1'b1;
		end
	end

	a_edges_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!(zpos && zneg));

endmodule

`default_nettype wire

/* source/win_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module win_mapper import zmem_pkg::*; (
	input  logic                fclk,
	input  logic                rst_n,
	input  logic                zneg,
	input  logic [ZA_W-1:0]     za,
	input  logic [7:0]          zd_in,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                m1_n,
	input  logic                rfsh_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic [4*PAGE_W-1:0] win_page,
	input  logic [3:0]          win_romnram,
	input  logic                romrw_en,
	output logic [4:0]          rompg,
	output logic                csrom,
	output logic                romoe_n,
	output logic                romwe_n,
	output logic                zd_ena,
	zacc_if.mapper              acc
);

	logic [1:0]        win;
	logic [PAGE_W-1:0] page;
	logic              romnram;
	logic              mem_acc;
	logic              ram_acc;
	logic              r_mreq_n;
	logic              r_iorq_n;
	logic              beg_r;

	// window from the top two address bits
	assign win     = za[ZA_W-1 -: 2];
	assign page    = win_page[win*PAGE_W +: PAGE_W];
	assign romnram = win_romnram[win];
	assign rompg   = page[4:0];

	// refresh cycles are not memory accesses
	assign mem_acc = ~mreq_n & rfsh_n;
	assign ram_acc = mem_acc & ~romnram;

	// rom chip, select plus strobes
	assign csrom   = mem_acc & romnram;
	assign romoe_n = rd_n | mreq_n;
	assign romwe_n = ~(csrom & ~wr_n & romrw_en);

	// ram read data goes out on the z80 bus
	assign zd_ena = ram_acc & ~rd_n;

	assign acc.ramrd    = ram_acc & ~rd_n;
	assign acc.ramwr    = ram_acc & ~wr_n;
	assign acc.opfetch  = ram_acc & ~m1_n;
	assign acc.dram_beg = beg_r;
	assign acc.daddr    = {page, za[13:1]};
	assign acc.bsel     = za[0];
	assign acc.wdata    = zd_in;
	assign acc.romsel   = csrom;
	// falling edge of iorq_n
	assign acc.iocyc    = ~iorq_n & r_iorq_n;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			r_mreq_n <= 1'b1;
			r_iorq_n <= 1'b1;
			beg_r    <= 1'b0;
		end
		else
		begin
			r_iorq_n <= iorq_n;
			// first zneg that sees mreq low
			beg_r    <= zneg & r_mreq_n & ram_acc;
			if (zneg)
				r_mreq_n <= mreq_n | ~rfsh_n;
		end
	end

	a_bus_owner: assert property (@(posedge fclk) disable iff (!rst_n)
		!(csrom && zd_ena));

endmodule

`default_nettype wire

/* source/cpu_req_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_req_ctl import zmem_pkg::*; (
	input  logic     fclk,
	input  logic     rst_n,
	input  turbo_e   turbo,
	input  phase_t   phase,
	input  logic     zneg,
	output logic     cpu_stall,
	output logic [7:0] zd_out,
	zacc_if.ctl      acc,
	dram_cpu_if.cpu  dc
);

	logic            t14;
	logic            accept;
	logic            beg_rd;
	logic            hit;
	logic            go;
	logic            pend;
	logic            rnw_r;
	logic            rd_wait;
	logic            ramrd_r;
	logic            ramwr_r;
	logic            req357;
	logic            inval;
	logic            cache_vld;
	logic [DA_W-1:0] cache_addr;
	logic [15:0]     rd_buf;

	// both top codes mean 14 MHz
	assign t14    = turbo[1];
	assign accept = dc.cpu_req & dc.cpu_next & (phase == PH_C3);

	// fetch and read show rd_n at begin time
	assign beg_rd = acc.ramrd | acc.opfetch;
	assign hit    = cache_vld && (cache_addr == acc.daddr);
	// a write always goes out, a read only on a miss
	assign go     = t14 & acc.dram_beg & (~hit | ~beg_rd);

	// slow modes, request on a new rd/wr seen at c3
	assign req357 = ~t14 & ((acc.ramrd & ~ramrd_r) | (acc.ramwr & ~ramwr_r));

	assign dc.cpu_req    = t14 ? (pend | go) : req357;
	assign dc.cpu_rnw    = t14 ? (go ? beg_rd : rnw_r) : acc.ramrd;
	assign dc.cpu_addr   = acc.daddr;
	assign dc.cpu_wrdata = acc.wdata;
	assign dc.cpu_wrbsel = acc.bsel;

	// reads hold the cpu until data, writes only until the slot frees
	assign cpu_stall = t14 ?
		((go & (beg_rd | ~dc.cpu_next)) | rd_wait | (pend & ~rnw_r & ~dc.cpu_next)) :
		(req357 & ~dc.cpu_next);

	// rom access, write or io cycle drops the cached halfword
	assign inval = (zneg & acc.romsel) | acc.ramwr | acc.iocyc | (acc.dram_beg & ~beg_rd);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend      <= 1'b0;
			rnw_r     <= 1'b1;
			rd_wait   <= 1'b0;
			ramrd_r   <= 1'b0;
			ramwr_r   <= 1'b0;
			cache_vld <= 1'b0;
		end
		else
		begin
			if (accept)
				pend <= 1'b0;
			else if (go)
				pend <= 1'b1;
			if (go)
				rnw_r <= beg_rd;
			// stays up through the strobe cycle so rd_buf is loaded first
			if (dc.cpu_strobe)
				rd_wait <= 1'b0;
			else if (go && beg_rd)
				rd_wait <= 1'b1;
			if ((phase == PH_C3) && !cpu_stall)
			begin
				ramrd_r <= acc.ramrd;
				ramwr_r <= acc.ramwr;
			end
			if (inval)
				cache_vld <= 1'b0;
			else if (dc.cpu_strobe)
				cache_vld <= 1'b1;
		end
	end

	// read buffer and cache tag
	always_ff @(posedge fclk)
	begin
		if (dc.cpu_strobe)
		begin
			rd_buf     <= dc.cpu_rddata;
			cache_addr <= acc.daddr;
		end
	end

	assign zd_out = acc.bsel ? rd_buf[15:8] : rd_buf[7:0];

	// a request only drops once the slot takes it
	a_req_held: assert property (@(posedge fclk) disable iff (!rst_n)
		dc.cpu_req && !accept |=> dc.cpu_req);

endmodule

`default_nettype wire

/* source/dram_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_slot import zmem_pkg::*; #(
	parameter int STEAL_EVERY = 0,
	parameter int RAM_AW      = 10
) (
	input  logic     fclk,
	input  logic     rst_n,
	input  phase_t   phase,
	dram_cpu_if.slot dc
);

	localparam int CW = (STEAL_EVERY > 1) ? $clog2(STEAL_EVERY) : 1;

	logic [CW-1:0]     cyc_cnt;
	logic              steal;
	logic              accept;
	logic              acc_rd;
	logic [RAM_AW-1:0] ram_a;
	logic [2:0]        rd_pipe;
	logic [15:0]       rd_q;
	logic [15:0]       mem [0:(1<<RAM_AW)-1];

	// last phase cycle of each group goes to video
	assign steal       = (STEAL_EVERY != 0) && (cyc_cnt == CW'(STEAL_EVERY - 1));
	assign dc.cpu_next = ~steal;

	assign accept = dc.cpu_req & dc.cpu_next & (phase == PH_C3);
	assign acc_rd = accept & dc.cpu_rnw;
	// higher address bits wrap
	assign ram_a  = dc.cpu_addr[RAM_AW-1:0];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cyc_cnt <= '0;
			rd_pipe <= '0;
		end
		else
		begin
			// counts whole phase cycles
			if (phase == PH_C3)
			begin
				if (cyc_cnt == CW'(STEAL_EVERY - 1))
					cyc_cnt <= '0;
				else
					cyc_cnt <= cyc_cnt + 1'b1;
			end
			// c3 accept, strobe at the next c2
			rd_pipe <= {rd_pipe[1:0], acc_rd};
		end
	end

	// halfword ram, byte lane writes
	always_ff @(posedge fclk)
	begin
		if (accept && !dc.cpu_rnw)
		begin
			if (dc.cpu_wrbsel)
				mem[ram_a][15:8] <= dc.cpu_wrdata;
			else
				mem[ram_a][7:0] <= dc.cpu_wrdata;
		end
		if (acc_rd)
			rd_q <= mem[ram_a];
	end

	assign dc.cpu_strobe = rd_pipe[2];
	assign dc.cpu_rddata = rd_q;

	a_strobe_src: assert property (@(posedge fclk) disable iff (!rst_n)
		dc.cpu_strobe |-> (phase == PH_C2) &&
			$past(dc.cpu_req && dc.cpu_rnw && dc.cpu_next, 3));

endmodule

`default_nettype wire

/* source/zmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zmem_top import zmem_pkg::*; #(
	parameter int STEAL_EVERY = 0,
	parameter int RAM_AW      = 10
) (
	input  logic                fclk,
	input  logic                rst_n,
	input  turbo_e              turbo,
	input  logic [ZA_W-1:0]     za,
	input  logic [7:0]          zd_in,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                m1_n,
	input  logic                rfsh_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic [4*PAGE_W-1:0] win_page,
	input  logic [3:0]          win_romnram,
	input  logic                romrw_en,
	output logic [7:0]          zd_out,
	output logic                zd_ena,
	output logic                zpos,
	output logic                zneg,
	output logic                cpu_stall,
	output logic                cpu_req,
	output logic [4:0]          rompg,
	output logic                csrom,
	output logic                romoe_n,
	output logic                romwe_n
);

	phase_t phase;

	zacc_if     acc ();
	dram_cpu_if dc ();

	assign cpu_req = dc.cpu_req;

	zclk_gen i_zclk_gen (.fclk, .rst_n, .turbo, .stall(cpu_stall), .zpos, .zneg, .phase);

	win_mapper i_win_mapper (.fclk, .rst_n, .zneg, .za, .zd_in, .mreq_n, .iorq_n, .m1_n,
		.rfsh_n, .rd_n, .wr_n, .win_page, .win_romnram, .romrw_en, .rompg, .csrom,
		.romoe_n, .romwe_n, .zd_ena, .acc(acc.mapper));

	cpu_req_ctl i_cpu_req_ctl (.fclk, .rst_n, .turbo, .phase, .zneg, .cpu_stall, .zd_out,
		.acc(acc.ctl), .dc(dc.cpu));

	dram_slot #(.STEAL_EVERY(STEAL_EVERY), .RAM_AW(RAM_AW)) i_dram_slot (.fclk, .rst_n,
		.phase, .dc(dc.slot));

endmodule

`default_nettype wire

/* sim/tb_zmem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_zmem import zmem_pkg::*; ();

	localparam int FCLK_NS     = 4;
	// wide enough that the low page bits reach the ram
	localparam int RAM_AW      = 15;
	localparam int N_RW        = 8;
	// bus cycles in the whole run rounded up
	localparam int N_CYC       = 64;
	// 8 slowest zclk periods per bus cycle
	localparam int WATCHDOG_NS = N_CYC * 8 * 8 * FCLK_NS + 4000;

	logic        fclk;
	logic        rst_n;
	turbo_e      turbo;
	logic [15:0] za;
	logic [7:0]  zd_in;
	logic        mreq_n;
	logic        iorq_n;
	logic        m1_n;
	logic        rfsh_n;
	logic        rd_n;
	logic        wr_n;
	logic [31:0] win_page;
	logic [3:0]  win_romnram;
	logic        romrw_en;
	logic [7:0]  zd_out;
	logic        zd_ena;
	logic        zpos;
	logic        zneg;
	logic        cpu_stall;
	logic        cpu_req;
	logic [4:0]  rompg;
	logic        csrom;
	logic        romoe_n;
	logic        romwe_n;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          req_cnt = 0;
	int          stall_cnt = 0;
	int          we_cnt = 0;
	int          cs_cnt = 0;
	int          ena_cnt = 0;
	// byte model of the wrapped backing ram
	logic [7:0]  ref_mem [0:(2<<RAM_AW)-1];
	logic        known [0:(2<<RAM_AW)-1];
	logic [15:0] addr_q [$];

	zmem_top #(.STEAL_EVERY(3), .RAM_AW(RAM_AW)) i_zmem_top (.fclk, .rst_n, .turbo, .za,
		.zd_in, .mreq_n, .iorq_n, .m1_n, .rfsh_n, .rd_n, .wr_n, .win_page, .win_romnram,
		.romrw_en, .zd_out, .zd_ena, .zpos, .zneg, .cpu_stall, .cpu_req, .rompg, .csrom,
		.romoe_n, .romwe_n);

	always #(FCLK_NS / 2) fclk = ~fclk;

	// fibonacci lfsr on taps 32 22 2 1
	// one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] page_of(input logic [15:0] addr);
		return win_page[addr[15:14]*PAGE_W +: PAGE_W];
	endfunction

	function automatic logic [4:0] rom_page(input logic [15:0] addr);
		logic [7:0] p;
		p = page_of(addr);
		return p[4:0];
	endfunction

	// wrapped halfword address above the byte lane
	function automatic int ref_idx(input logic [15:0] addr);
		logic [DA_W-1:0] da;
		da = {page_of(addr), addr[13:1]};
		return int'({da[RAM_AW-1:0], addr[0]});
	endfunction

	// returns one fclk after the edge is seen
	task automatic wait_zpos();
		@(negedge fclk);
		while (!zpos)
			@(negedge fclk);
		@(negedge fclk);
	endtask

	task automatic wait_zneg();
		@(negedge fclk);
		while (!zneg)
			@(negedge fclk);
		@(negedge fclk);
	endtask

	// z80 memory cycle from T1 to the T3 falling edge
	task automatic bus_cycle(input logic [15:0] addr, input logic is_wr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		wait_zpos();
		za     = addr;
		zd_in  = wdat;
		mreq_n = 1'b0;
		rd_n   = is_wr;
		wr_n   = ~is_wr;
		wait_zneg();
		wait_zpos();
		wait_zneg();
		wait_zpos();
		wait_zneg();
		rdat   = zd_out;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		// idle zneg rearms the begin detector
		wait_zpos();
		wait_zneg();
	endtask

	task automatic ram_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] dummy;
		bus_cycle(addr, 1'b1, data, dummy);
		ref_mem[ref_idx(addr)] = data;
		known[ref_idx(addr)]   = 1'b1;
	endtask

	task automatic ram_read(input logic [15:0] addr, output int nreq);
		int         r0;
		int         s0;
		int         e0;
		int         idx;
		logic [7:0] got;
		idx = ref_idx(addr);
		r0  = req_cnt;
		s0  = stall_cnt;
		e0  = ena_cnt;
		bus_cycle(addr, 1'b0, 8'h00, got);
		nreq = req_cnt - r0;
		if (known[idx])
		begin
			checks++;
			assert (got === ref_mem[idx])
			else
			begin
				errors++;
				$display("FAIL zd_out at %h got %h exp %h", addr, got, ref_mem[idx]);
			end
		end
		checks++;
		assert (ena_cnt > e0)
		else
		begin
			errors++;
			$display("ram read at %h never raised zd_ena", addr);
		end
		if (turbo == T14 && nreq > 0)
		begin
			checks++;
			assert (stall_cnt > s0)
			else
			begin
				errors++;
				$display("missed read at %h never stalled the cpu clock", addr);
			end
		end
	endtask

	task automatic rom_cycle(input logic [15:0] addr, input logic is_wr);
		int         r0;
		int         w0;
		int         c0;
		int         e0;
		logic [7:0] dummy;
		r0 = req_cnt;
		w0 = we_cnt;
		c0 = cs_cnt;
		e0 = ena_cnt;
		bus_cycle(addr, is_wr, 8'(take_bits(8)), dummy);
		checks++;
		assert (req_cnt == r0 && cs_cnt > c0 && ena_cnt == e0)
		else
		begin
			errors++;
			$display("rom access at %h raised cpu_req or zd_ena or missed csrom", addr);
		end
		if (is_wr)
		begin
			checks++;
			assert ((we_cnt > w0) == romrw_en)
			else
			begin
				errors++;
				$display("FAIL romwe_n pulses %h with romrw_en %h", we_cnt - w0, romrw_en);
			end
		end
	endtask

	task automatic io_cycle();
		wait_zpos();
		za     = 16'h00fe;
		iorq_n = 1'b0;
		wait_zneg();
		wait_zpos();
		wait_zneg();
		iorq_n = 1'b1;
		wait_zpos();
		wait_zneg();
	endtask

	task automatic expect_req(input int nreq, input logic want, input string what);
		checks++;
		assert ((nreq > 0) == want)
		else
		begin
			errors++;
			$display("FAIL cpu_req pulses %h want %h on %s", nreq, want, what);
		end
	endtask

	// cycle counters for the bus tasks
	always @(negedge fclk)
	begin
		if (rst_n)
		begin
			if (cpu_req)
				req_cnt++;
			if (cpu_stall)
				stall_cnt++;
			if (!romwe_n)
				we_cnt++;
			if (csrom)
				cs_cnt++;
			if (zd_ena)
				ena_cnt++;
		end
	end

	a_stall_freeze: assert property (@(posedge fclk) disable iff (!rst_n)
		cpu_stall |-> !zpos && !zneg)
		else
		begin
			errors++;
			$display("FAIL zpos %h zneg %h while cpu_stall", zpos, zneg);
		end

	a_edges_apart: assert property (@(posedge fclk) disable iff (!rst_n) !(zpos && zneg))
		else
		begin
			errors++;
			$display("zpos and zneg fired together");
		end

	a_romoe: assert property (@(posedge fclk) disable iff (!rst_n) romoe_n == (rd_n | mreq_n))
		else
		begin
			errors++;
			$display("FAIL romoe_n %h exp %h", romoe_n, rd_n | mreq_n);
		end

	a_romwe: assert property (@(posedge fclk) disable iff (!rst_n) !romwe_n |-> romrw_en)
		else
		begin
			errors++;
			$display("romwe_n went low with romrw_en clear");
		end

	a_rompg: assert property (@(posedge fclk) disable iff (!rst_n)
		csrom |-> rompg == rom_page(za))
		else
		begin
			errors++;
			$display("FAIL rompg %h exp %h", rompg, rom_page(za));
		end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout, the bus cycles never finished");
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		logic [15:0] a;
		logic [7:0]  d;
		logic [1:0]  w;
		int          nreq;
		fclk        = 1'b0;
		rst_n       = 1'b0;
		turbo       = T35;
		za          = '0;
		zd_in       = '0;
		mreq_n      = 1'b1;
		iorq_n      = 1'b1;
		m1_n        = 1'b1;
		rfsh_n      = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		// window 0 is rom and windows 1 and 2 share a page
		win_page    = {8'h34, 8'h12, 8'h12, 8'h05};
		win_romnram = 4'b0001;
		romrw_en    = 1'b0;
		lfsr        = 32'h856e_7fa0;
		for (int i = 0; i < (2 << RAM_AW); i++)
			known[i] = 1'b0;
		repeat (3) @(negedge fclk);
		rst_n = 1'b1;

		// idle outputs before any bus cycle
		repeat (8)
		begin
			@(negedge fclk);
			checks++;
			assert (!cpu_req && !cpu_stall && !zd_ena && !csrom && romoe_n && romwe_n)
			else
			begin
				errors++;
				$display("FAIL idle req %h stall %h ena %h cs %h oe_n %h we_n %h",
					cpu_req, cpu_stall, zd_ena, csrom, romoe_n, romwe_n);
			end
		end

		// writes then reads in T35, T7, T14
		for (int m = 0; m < 3; m++)
		begin
			turbo = (m == 0) ? T35 : (m == 1) ? T7 : T14;
			addr_q.delete();
			for (int i = 0; i < N_RW; i++)
			begin
				w = 2'(take_bits(2));
				if (w == 2'd0)
					w = 2'd3;
				a = {w, 14'(take_bits(14))};
				addr_q.push_back(a);
				ram_write(a, 8'(take_bits(8)));
			end
			foreach (addr_q[i])
				ram_read(addr_q[i], nreq);
		end

		// window alias and rom accesses
		a = {2'b01, 14'(take_bits(14))};
		d = 8'(take_bits(8));
		ram_write(a, d);
		// same offset in window 3 sits on another page
		ram_write({2'b11, a[13:0]}, ~d);
		ram_read({2'b10, a[13:0]}, nreq);
		ram_read({2'b11, a[13:0]}, nreq);
		rom_cycle(16'h0123, 1'b0);
		rom_cycle(16'h0124, 1'b1);
		romrw_en = 1'b1;
		rom_cycle(16'h0125, 1'b1);
		romrw_en = 1'b0;

		// cache hits and invalidation
		a = {2'b11, 14'(take_bits(14))};
		ram_write(a, 8'(take_bits(8)));
		ram_write(a ^ 16'h0001, 8'(take_bits(8)));
		ram_read(a, nreq);
		expect_req(nreq, 1'b1, "read after a write");
		ram_read(a ^ 16'h0001, nreq);
		expect_req(nreq, 1'b0, "second read of the same halfword");
		rom_cycle(16'h0456, 1'b0);
		ram_read(a, nreq);
		expect_req(nreq, 1'b1, "read after a rom access");
		io_cycle();
		ram_read(a, nreq);
		expect_req(nreq, 1'b1, "read after an io cycle");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/zmem_pkg.sv
source/zmem_ifs.sv
source/zclk_gen.sv
source/win_mapper.sv
source/cpu_req_ctl.sv
source/dram_slot.sv
source/zmem_top.sv
sim/tb_zmem.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_zmem
FILELIST = sim.f
OBJ_DIR  = obj_dir
PASS_MSG = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
